// ==== include/memreq_cfg.svh ====
`ifndef MEMREQ_CFG_SVH
`define MEMREQ_CFG_SVH

// Word address, data word and tag widths
`define MEMREQ_ADDR_W 28
`define MEMREQ_DATA_W 32
`define MEMREQ_TAG_W 4

// Write-word buffer entries
`define MEMREQ_WBUF_DEPTH 8

// Opcode byte values on the byte streams
`define MEMREQ_OP_STORE 8'h01
`define MEMREQ_OP_FETCH 8'h80
`define MEMREQ_OP_WDONE 8'h02
`define MEMREQ_OP_WFAIL 8'h03
`define MEMREQ_OP_RDATA 8'h81
`define MEMREQ_OP_RFAIL 8'h82

`endif

// ==== hw/memreq_cmd_pkg.sv ====
`include "memreq_cfg.svh"

package memreq_cmd_pkg;

  // Every opcode that can appear on either byte stream
  typedef enum logic [7:0] {
    OP_NOP   = 8'h00,
    OP_STORE = `MEMREQ_OP_STORE,
    OP_WDONE = `MEMREQ_OP_WDONE,
    OP_WFAIL = `MEMREQ_OP_WFAIL,
    OP_FETCH = `MEMREQ_OP_FETCH,
    OP_RDATA = `MEMREQ_OP_RDATA,
    OP_RFAIL = `MEMREQ_OP_RFAIL
  } opcode_e;

  typedef enum logic [2:0] {
    PS_IDLE,    // Waiting for an opcode byte
    PS_HEADER,  // Length and address/tag bytes
    PS_WDATA,   // STORE payload
    PS_LAUNCH,  // Waiting for the target engine
    PS_DRAIN    // Skipping to end of packet
  } parse_state_e;

  // First byte of every response packet
  typedef enum logic [7:0] {
    RESP_WDONE = `MEMREQ_OP_WDONE,
    RESP_WFAIL = `MEMREQ_OP_WFAIL,
    RESP_RDATA = `MEMREQ_OP_RDATA,
    RESP_RFAIL = `MEMREQ_OP_RFAIL
  } resp_code_e;

endpackage

// ==== hw/memreq_mem_pkg.sv ====
`include "memreq_cfg.svh"

package memreq_mem_pkg;

  typedef logic [`MEMREQ_ADDR_W-1:0] addr_t;  // Word address
  typedef logic [`MEMREQ_DATA_W-1:0] word_t;
  typedef logic [`MEMREQ_TAG_W-1:0] tag_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ISSUE,  // Waiting for a buffered word
    WR_WAIT,   // Write request outstanding
    WR_RESP    // Sending the two-byte response
  } wr_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ISSUE,  // First cycle of a read request
    RD_WAIT,   // Read request held until ack
    RD_SEND    // Serialising header and word bytes
  } rd_state_e;

  // Owners of the memory port and the outbound stream
  typedef enum logic {
    REQ_WRITER,
    REQ_READER
  } requester_e;

endpackage

// ==== hw/cmd_parser.sv ====
module cmd_parser (
  input  logic                  bus_clock,
  input  logic                  bus_reset,
  input  logic                  s_tvalid_i,
  output logic                  s_tready_o,
  input  logic                  s_tlast_i,
  input  logic [7:0]            s_tdata_i,
  output logic                  wr_launch_o,
  output logic                  rd_launch_o,
  output memreq_mem_pkg::addr_t cmd_addr_o,
  output logic [7:0]            cmd_count_o,  // Words minus one
  output memreq_mem_pkg::tag_t  cmd_tag_o,
  input  logic                  wr_busy_i,
  input  logic                  rd_busy_i,
  output logic                  wword_valid_o,
  input  logic                  wword_ready_i,
  output logic                  wword_last_o,
  output memreq_mem_pkg::word_t wword_data_o
);

  memreq_cmd_pkg::parse_state_e state_q;
  memreq_cmd_pkg::opcode_e      op_q;
  memreq_mem_pkg::word_t        acc_q;
  memreq_mem_pkg::word_t        acc_next;
  logic                         armed_q;     // Low only in the cycle after reset
  logic [2:0]                   hdr_cnt_q;
  logic                         hdr_last_q;
  logic [1:0]                   byte_idx_q;
  logic                         in_fire;
  logic                         is_store;
  logic                         launch;
  logic                         word_done;

  assign in_fire     = s_tvalid_i && s_tready_o;
  assign is_store    = (op_q == memreq_cmd_pkg::OP_STORE);
  assign launch      = (state_q == memreq_cmd_pkg::PS_LAUNCH) &&
                       (is_store ? !wr_busy_i : !rd_busy_i);
  assign wr_launch_o = launch && is_store;
  assign rd_launch_o = launch && !is_store;
  assign word_done   = in_fire && (state_q == memreq_cmd_pkg::PS_WDATA) &&
                       (byte_idx_q == 2'd3 || s_tlast_i);

  always_comb begin
    case (state_q)
      memreq_cmd_pkg::PS_IDLE:   s_tready_o = armed_q;
      memreq_cmd_pkg::PS_HEADER: s_tready_o = 1'b1;
      memreq_cmd_pkg::PS_DRAIN:  s_tready_o = 1'b1;
      memreq_cmd_pkg::PS_WDATA:  s_tready_o = !wword_valid_o || wword_ready_i;
      default:                   s_tready_o = 1'b0;
    endcase
  end

  // Little-endian byte lane insert
  always_comb begin
    acc_next = acc_q;
    acc_next[{byte_idx_q, 3'b000} +: 8] = s_tdata_i;
  end

  always_ff @(posedge bus_clock) begin
    if (in_fire) begin
      case (state_q)
        memreq_cmd_pkg::PS_IDLE: op_q <= memreq_cmd_pkg::opcode_e'(s_tdata_i);
        memreq_cmd_pkg::PS_HEADER: begin
          case (hdr_cnt_q)
            3'd0: cmd_count_o <= s_tdata_i;
            3'd1: cmd_addr_o[7:0] <= s_tdata_i;
            3'd2: cmd_addr_o[15:8] <= s_tdata_i;
            3'd3: cmd_addr_o[23:16] <= s_tdata_i;
            default: {cmd_tag_o, cmd_addr_o[27:24]} <= s_tdata_i;  // Tag in the top nibble
          endcase
          hdr_last_q <= s_tlast_i;
        end
        memreq_cmd_pkg::PS_WDATA: acc_q <= acc_next;
        default: ;
      endcase
    end
    if (word_done) begin
      wword_data_o <= acc_next;
      wword_last_o <= s_tlast_i;
    end
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      wword_valid_o <= 1'b0;
    end else if (word_done) begin
      wword_valid_o <= 1'b1;
    end else if (wword_ready_i) begin
      wword_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state_q    <= memreq_cmd_pkg::PS_IDLE;
      armed_q    <= 1'b0;
      hdr_cnt_q  <= 3'd0;
      byte_idx_q <= 2'd0;
    end else begin
      armed_q <= 1'b1;
      case (state_q)
        memreq_cmd_pkg::PS_IDLE: begin
          hdr_cnt_q <= 3'd0;
          if (in_fire && !s_tlast_i) begin
            if (s_tdata_i == memreq_cmd_pkg::OP_STORE || s_tdata_i == memreq_cmd_pkg::OP_FETCH) begin
              state_q <= memreq_cmd_pkg::PS_HEADER;
            end else begin
              state_q <= memreq_cmd_pkg::PS_DRAIN;  // NOP and unknown opcodes
            end
          end
        end
        memreq_cmd_pkg::PS_HEADER: begin
          if (in_fire) begin
            hdr_cnt_q <= hdr_cnt_q + 3'd1;
            if (hdr_cnt_q == 3'd4) begin
              state_q <= memreq_cmd_pkg::PS_LAUNCH;
            end else if (s_tlast_i) begin
              state_q <= memreq_cmd_pkg::PS_IDLE;  // Truncated header
            end
          end
        end
        memreq_cmd_pkg::PS_LAUNCH: begin
          byte_idx_q <= 2'd0;
          if (launch && is_store) begin
            state_q <= memreq_cmd_pkg::PS_WDATA;
          end else if (launch) begin
            state_q <= hdr_last_q ? memreq_cmd_pkg::PS_IDLE : memreq_cmd_pkg::PS_DRAIN;
          end
        end
        memreq_cmd_pkg::PS_WDATA: begin
          if (in_fire) begin
            byte_idx_q <= byte_idx_q + 2'd1;
            if (s_tlast_i) state_q <= memreq_cmd_pkg::PS_IDLE;
          end
        end
        default: begin
          if (in_fire && s_tlast_i) state_q <= memreq_cmd_pkg::PS_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== hw/write_engine.sv ====
`include "memreq_cfg.svh"

module write_engine (
  input  logic                  bus_clock,
  input  logic                  bus_reset,
  input  logic                  wr_launch_i,
  input  memreq_mem_pkg::addr_t cmd_addr_i,
  input  logic [7:0]            cmd_count_i,
  input  memreq_mem_pkg::tag_t  cmd_tag_i,
  output logic                  wr_busy_o,
  input  logic                  wword_valid_i,
  output logic                  wword_ready_o,
  input  logic                  wword_last_i,
  input  memreq_mem_pkg::word_t wword_data_i,
  output logic                  req_o,
  output logic                  we_o,
  output memreq_mem_pkg::addr_t addr_o,
  output memreq_mem_pkg::word_t wdata_o,
  input  logic                  ack_i,
  input  logic                  err_i,
  output logic                  tx_valid_o,
  input  logic                  tx_ready_i,
  output logic                  tx_last_o,
  output logic [7:0]            tx_data_o
);

  localparam int PTR_W = $clog2(`MEMREQ_WBUF_DEPTH);

  memreq_mem_pkg::wr_state_e state_q;
  memreq_mem_pkg::word_t     buf_data [`MEMREQ_WBUF_DEPTH];
  logic                      buf_last [`MEMREQ_WBUF_DEPTH];
  logic [PTR_W:0]            wr_ptr_q;  // Extra bit tells full from empty
  logic [PTR_W:0]            rd_ptr_q;
  memreq_mem_pkg::addr_t     addr_q;
  memreq_mem_pkg::tag_t      tag_q;
  logic [7:0]                left_q;
  logic                      err_q;
  logic                      tag_sel_q;
  logic                      buf_empty;
  logic                      buf_full;
  logic                      final_word;

  assign buf_empty     = (wr_ptr_q == rd_ptr_q);
  assign buf_full      = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                         (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);
  assign wword_ready_o = !buf_full;
  // Short payloads end on the stream's last flag
  assign final_word    = buf_last[rd_ptr_q[PTR_W-1:0]] || (left_q == 8'd0);

  // A buffered word asks for the port at once
  assign req_o     = (state_q == memreq_mem_pkg::WR_WAIT) ||
                     ((state_q == memreq_mem_pkg::WR_ISSUE) && !buf_empty);
  assign we_o      = req_o;
  assign addr_o    = addr_q;
  assign wdata_o   = buf_data[rd_ptr_q[PTR_W-1:0]];
  assign wr_busy_o = (state_q != memreq_mem_pkg::WR_IDLE);

  assign tx_valid_o = (state_q == memreq_mem_pkg::WR_RESP);
  assign tx_last_o  = tag_sel_q;
  assign tx_data_o  = tag_sel_q ? 8'(tag_q) :
                      (err_q ? memreq_cmd_pkg::RESP_WFAIL : memreq_cmd_pkg::RESP_WDONE);

  always_ff @(posedge bus_clock) begin
    if (wword_valid_i && !buf_full) begin
      buf_data[wr_ptr_q[PTR_W-1:0]] <= wword_data_i;
      buf_last[wr_ptr_q[PTR_W-1:0]] <= wword_last_i;
    end
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (wword_valid_i && !buf_full) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (req_o && ack_i) rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state_q   <= memreq_mem_pkg::WR_IDLE;
      err_q     <= 1'b0;
      tag_sel_q <= 1'b0;
    end else begin
      case (state_q)
        memreq_mem_pkg::WR_IDLE: begin
          if (wr_launch_i) begin
            addr_q  <= cmd_addr_i;
            left_q  <= cmd_count_i;
            tag_q   <= cmd_tag_i;
            err_q   <= 1'b0;
            state_q <= memreq_mem_pkg::WR_ISSUE;
          end
        end
        memreq_mem_pkg::WR_ISSUE, memreq_mem_pkg::WR_WAIT: begin
          if (req_o && ack_i) begin
            err_q   <= err_q | err_i;  // Any failed word fails the packet
            addr_q  <= addr_q + 1'b1;
            left_q  <= left_q - 8'd1;
            state_q <= final_word ? memreq_mem_pkg::WR_RESP : memreq_mem_pkg::WR_ISSUE;
          end else if (req_o) begin
            state_q <= memreq_mem_pkg::WR_WAIT;
          end
        end
        default: begin
          if (tx_ready_i) begin
            tag_sel_q <= !tag_sel_q;
            if (tag_sel_q) state_q <= memreq_mem_pkg::WR_IDLE;
          end
        end
      endcase
    end
  end

endmodule

// ==== hw/read_engine.sv ====
module read_engine (
  input  logic                  bus_clock,
  input  logic                  bus_reset,
  input  logic                  rd_launch_i,
  input  memreq_mem_pkg::addr_t cmd_addr_i,
  input  logic [7:0]            cmd_count_i,
  input  memreq_mem_pkg::tag_t  cmd_tag_i,
  output logic                  rd_busy_o,
  output logic                  req_o,
  output memreq_mem_pkg::addr_t addr_o,
  input  logic                  ack_i,
  input  memreq_mem_pkg::word_t rdata_i,
  input  logic                  err_i,
  output logic                  tx_valid_o,
  input  logic                  tx_ready_i,
  output logic                  tx_last_o,
  output logic [7:0]            tx_data_o
);

  memreq_mem_pkg::rd_state_e state_q;
  memreq_mem_pkg::addr_t     addr_q;
  memreq_mem_pkg::tag_t      tag_q;
  memreq_mem_pkg::word_t     word_q;
  logic [7:0]                left_q;
  logic                      first_q;
  logic                      fail_q;
  // 0 code, 1 tag, 4..7 word bytes
  logic [2:0]                sel_q;

  assign req_o      = (state_q == memreq_mem_pkg::RD_ISSUE) ||
                      (state_q == memreq_mem_pkg::RD_WAIT);
  assign addr_o     = addr_q;
  assign rd_busy_o  = (state_q != memreq_mem_pkg::RD_IDLE);
  assign tx_valid_o = (state_q == memreq_mem_pkg::RD_SEND);
  assign tx_last_o  = (sel_q == 3'd7) && (left_q == 8'd0);

  always_comb begin
    if (sel_q[2]) begin
      tx_data_o = word_q[{sel_q[1:0], 3'b000} +: 8];  // LSB first
    end else if (sel_q[0]) begin
      tx_data_o = 8'(tag_q);
    end else begin
      tx_data_o = fail_q ? memreq_cmd_pkg::RESP_RFAIL : memreq_cmd_pkg::RESP_RDATA;
    end
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state_q <= memreq_mem_pkg::RD_IDLE;
      first_q <= 1'b0;
      fail_q  <= 1'b0;
      sel_q   <= 3'd0;
    end else begin
      case (state_q)
        memreq_mem_pkg::RD_IDLE: begin
          if (rd_launch_i) begin
            addr_q  <= cmd_addr_i;
            left_q  <= cmd_count_i;
            tag_q   <= cmd_tag_i;
            first_q <= 1'b1;
            state_q <= memreq_mem_pkg::RD_ISSUE;
          end
        end
        memreq_mem_pkg::RD_ISSUE, memreq_mem_pkg::RD_WAIT: begin
          if (ack_i) begin
            word_q  <= rdata_i;
            first_q <= 1'b0;
            sel_q   <= first_q ? 3'd0 : 3'd4;  // Header only ahead of the first word
            if (first_q) fail_q <= err_i;
            state_q <= memreq_mem_pkg::RD_SEND;
          end else begin
            state_q <= memreq_mem_pkg::RD_WAIT;
          end
        end
        default: begin
          // Next read waits until this word has left
          if (tx_ready_i) begin
            if (sel_q == 3'd7) begin
              if (left_q == 8'd0) begin
                state_q <= memreq_mem_pkg::RD_IDLE;
              end else begin
                left_q  <= left_q - 8'd1;
                addr_q  <= addr_q + 1'b1;
                state_q <= memreq_mem_pkg::RD_ISSUE;
              end
            end else begin
              sel_q <= (sel_q == 3'd1) ? 3'd4 : sel_q + 3'd1;
            end
          end
        end
      endcase
    end
  end

endmodule

// ==== hw/mem_arbiter.sv ====
module mem_arbiter (
  input  logic                  bus_clock,
  input  logic                  bus_reset,
  input  logic                  wr_req_i,
  input  logic                  wr_we_i,
  input  memreq_mem_pkg::addr_t wr_addr_i,
  input  memreq_mem_pkg::word_t wr_wdata_i,
  output logic                  wr_ack_o,
  output logic                  wr_err_o,
  input  logic                  rd_req_i,
  input  memreq_mem_pkg::addr_t rd_addr_i,
  output logic                  rd_ack_o,
  output memreq_mem_pkg::word_t rd_rdata_o,
  output logic                  rd_err_o,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output memreq_mem_pkg::addr_t mem_addr_o,
  output memreq_mem_pkg::word_t mem_wdata_o,
  input  logic                  mem_ack_i,
  input  memreq_mem_pkg::word_t mem_rdata_i,
  input  logic                  mem_err_i
);

  memreq_mem_pkg::requester_e owner_q;
  memreq_mem_pkg::requester_e sel;
  logic                       lock_q;  // Request in flight, owner frozen
  logic                       sel_wr;

  always_comb begin
    if (lock_q) sel = owner_q;
    else if (wr_req_i) sel = memreq_mem_pkg::REQ_WRITER;
    else sel = memreq_mem_pkg::REQ_READER;
  end

  assign sel_wr      = (sel == memreq_mem_pkg::REQ_WRITER);
  assign mem_req_o   = sel_wr ? wr_req_i : rd_req_i;
  assign mem_we_o    = sel_wr && wr_we_i;
  assign mem_addr_o  = sel_wr ? wr_addr_i : rd_addr_i;
  assign mem_wdata_o = wr_wdata_i;

  assign wr_ack_o   = mem_ack_i && sel_wr;
  assign wr_err_o   = mem_err_i && sel_wr;
  assign rd_ack_o   = mem_ack_i && !sel_wr;
  assign rd_err_o   = mem_err_i && !sel_wr;
  assign rd_rdata_o = mem_rdata_i;  // Only the reader takes data

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      lock_q  <= 1'b0;
      owner_q <= memreq_mem_pkg::REQ_WRITER;
    end else if (mem_req_o && !mem_ack_i) begin
      lock_q  <= 1'b1;
      owner_q <= sel;
    end else if (mem_ack_i) begin
      lock_q <= 1'b0;
    end
  end

endmodule

// ==== hw/resp_arbiter.sv ====
module resp_arbiter (
  input  logic       bus_clock,
  input  logic       bus_reset,
  input  logic       wr_tx_valid_i,
  output logic       wr_tx_ready_o,
  input  logic       wr_tx_last_i,
  input  logic [7:0] wr_tx_data_i,
  input  logic       rd_tx_valid_i,
  output logic       rd_tx_ready_o,
  input  logic       rd_tx_last_i,
  input  logic [7:0] rd_tx_data_i,
  output logic       m_tvalid_o,
  input  logic       m_tready_i,
  output logic       m_tlast_o,
  output logic [7:0] m_tdata_o
);

  memreq_mem_pkg::requester_e grant_q;
  memreq_mem_pkg::requester_e sel;
  logic                       active_q;  // Packet under way
  logic                       sel_wr;

  // Fresh pick only between packets, writer first
  always_comb begin
    if (active_q) sel = grant_q;
    else if (wr_tx_valid_i) sel = memreq_mem_pkg::REQ_WRITER;
    else sel = memreq_mem_pkg::REQ_READER;
  end

  assign sel_wr        = (sel == memreq_mem_pkg::REQ_WRITER);
  assign m_tvalid_o    = sel_wr ? wr_tx_valid_i : rd_tx_valid_i;
  assign m_tlast_o     = sel_wr ? wr_tx_last_i : rd_tx_last_i;
  assign m_tdata_o     = sel_wr ? wr_tx_data_i : rd_tx_data_i;
  assign wr_tx_ready_o = m_tready_i && sel_wr;
  assign rd_tx_ready_o = m_tready_i && !sel_wr;

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      active_q <= 1'b0;
      grant_q  <= memreq_mem_pkg::REQ_WRITER;
    end else if (m_tvalid_o && m_tready_i && m_tlast_o) begin
      active_q <= 1'b0;
    end else if (m_tvalid_o) begin
      active_q <= 1'b1;  // Locks even a byte not yet taken
      grant_q  <= sel;
    end
  end

endmodule

// ==== hw/memreq_top.sv ====
module memreq_top (
  input  logic                  bus_clock,
  input  logic                  bus_reset,
  input  logic                  s_tvalid_i,
  output logic                  s_tready_o,
  input  logic                  s_tlast_i,
  input  logic [7:0]            s_tdata_i,
  output logic                  m_tvalid_o,
  input  logic                  m_tready_i,
  output logic                  m_tlast_o,
  output logic [7:0]            m_tdata_o,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output memreq_mem_pkg::addr_t mem_addr_o,
  output memreq_mem_pkg::word_t mem_wdata_o,
  input  logic                  mem_ack_i,
  input  memreq_mem_pkg::word_t mem_rdata_i,
  input  logic                  mem_err_i
);

  // Parser to engines
  logic                  wr_launch, rd_launch, wr_busy, rd_busy;
  memreq_mem_pkg::addr_t cmd_addr;
  logic [7:0]            cmd_count;
  memreq_mem_pkg::tag_t  cmd_tag;
  logic                  wword_valid, wword_ready, wword_last;
  memreq_mem_pkg::word_t wword_data;

  // Engines to memory port
  logic                  wr_req, wr_we, wr_ack, wr_err;
  logic                  rd_req, rd_ack, rd_err;
  memreq_mem_pkg::addr_t wr_addr, rd_addr;
  memreq_mem_pkg::word_t wr_wdata, rd_rdata;

  // Engines to outbound stream
  logic                  wr_tx_valid, wr_tx_ready, wr_tx_last;
  logic                  rd_tx_valid, rd_tx_ready, rd_tx_last;
  logic [7:0]            wr_tx_data, rd_tx_data;

  cmd_parser i_cmd_parser (
    .bus_clock, .bus_reset, .s_tvalid_i, .s_tready_o, .s_tlast_i, .s_tdata_i,
    .wr_launch_o(wr_launch), .rd_launch_o(rd_launch), .cmd_addr_o(cmd_addr),
    .cmd_count_o(cmd_count), .cmd_tag_o(cmd_tag), .wr_busy_i(wr_busy), .rd_busy_i(rd_busy),
    .wword_valid_o(wword_valid), .wword_ready_i(wword_ready),
    .wword_last_o(wword_last), .wword_data_o(wword_data)
  );

  write_engine i_write_engine (
    .bus_clock, .bus_reset, .wr_launch_i(wr_launch), .cmd_addr_i(cmd_addr),
    .cmd_count_i(cmd_count), .cmd_tag_i(cmd_tag), .wr_busy_o(wr_busy),
    .wword_valid_i(wword_valid), .wword_ready_o(wword_ready),
    .wword_last_i(wword_last), .wword_data_i(wword_data),
    .req_o(wr_req), .we_o(wr_we), .addr_o(wr_addr), .wdata_o(wr_wdata),
    .ack_i(wr_ack), .err_i(wr_err), .tx_valid_o(wr_tx_valid), .tx_ready_i(wr_tx_ready),
    .tx_last_o(wr_tx_last), .tx_data_o(wr_tx_data)
  );

  read_engine i_read_engine (
    .bus_clock, .bus_reset, .rd_launch_i(rd_launch), .cmd_addr_i(cmd_addr),
    .cmd_count_i(cmd_count), .cmd_tag_i(cmd_tag), .rd_busy_o(rd_busy),
    .req_o(rd_req), .addr_o(rd_addr), .ack_i(rd_ack), .rdata_i(rd_rdata), .err_i(rd_err),
    .tx_valid_o(rd_tx_valid), .tx_ready_i(rd_tx_ready),
    .tx_last_o(rd_tx_last), .tx_data_o(rd_tx_data)
  );

  mem_arbiter i_mem_arbiter (
    .bus_clock, .bus_reset,
    .wr_req_i(wr_req), .wr_we_i(wr_we), .wr_addr_i(wr_addr), .wr_wdata_i(wr_wdata),
    .wr_ack_o(wr_ack), .wr_err_o(wr_err),
    .rd_req_i(rd_req), .rd_addr_i(rd_addr), .rd_ack_o(rd_ack),
    .rd_rdata_o(rd_rdata), .rd_err_o(rd_err),
    .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o, .mem_ack_i, .mem_rdata_i, .mem_err_i
  );

  resp_arbiter i_resp_arbiter (
    .bus_clock, .bus_reset,
    .wr_tx_valid_i(wr_tx_valid), .wr_tx_ready_o(wr_tx_ready),
    .wr_tx_last_i(wr_tx_last), .wr_tx_data_i(wr_tx_data),
    .rd_tx_valid_i(rd_tx_valid), .rd_tx_ready_o(rd_tx_ready),
    .rd_tx_last_i(rd_tx_last), .rd_tx_data_i(rd_tx_data),
    .m_tvalid_o, .m_tready_i, .m_tlast_o, .m_tdata_o
  );

endmodule

// ==== dv/memreq_tb_mem.sv ====
module memreq_tb_mem (
  input  logic                  bus_clock,
  input  logic                  bus_reset,
  input  logic                  req_i,
  input  logic                  we_i,
  input  memreq_mem_pkg::addr_t addr_i,
  input  memreq_mem_pkg::word_t wdata_i,
  output logic                  ack_o,
  output memreq_mem_pkg::word_t rdata_o,
  output logic                  err_o
);

  timeunit 1ns;
  timeprecision 1ps;

  memreq_mem_pkg::word_t store [256];
  int unsigned           rand_state = 81;
  int unsigned           delay_left;

  // Idle cycles before the next acknowledge, 0 to 3
  function int unsigned next_delay();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return (rand_state >> 16) % 4;
  endfunction

  initial begin
    for (int i = 0; i < 256; i++) begin
      store[i] = 32'h9e37_79b9 * (i + 1);  // Differs for every index
    end
    ack_o      = 1'b0;
    err_o      = 1'b0;
    rdata_o    = '0;
    delay_left = 0;
  end

  always @(negedge bus_clock) begin
    if (bus_reset) begin
      ack_o      <= 1'b0;
      err_o      <= 1'b0;
      delay_left <= 0;
    end else if (ack_o) begin
      ack_o <= 1'b0;  // One-cycle acknowledge
      err_o <= 1'b0;
    end else if (req_i) begin
      if (delay_left == 0) begin
        ack_o      <= 1'b1;
        err_o      <= addr_i[27];  // Error region
        rdata_o    <= store[addr_i[7:0]];
        if (we_i && !addr_i[27]) store[addr_i[7:0]] <= wdata_i;
        delay_left <= next_delay();
      end else begin
        delay_left <= delay_left - 1;
      end
    end
  end

endmodule

// ==== dv/memreq_tb.sv ====
module memreq_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 800;  // Longest test is the stalled burst
  localparam int TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_TEST;

  logic                  bus_clock;
  logic                  bus_reset;
  logic                  s_tvalid, s_tready, s_tlast;
  logic [7:0]            s_tdata;
  logic                  m_tvalid, m_tready, m_tlast;
  logic [7:0]            m_tdata;
  logic                  mem_req, mem_we, mem_ack, mem_err;
  memreq_mem_pkg::addr_t mem_addr;
  memreq_mem_pkg::word_t mem_wdata, mem_rdata;

  int unsigned           lcg_state = 81;
  memreq_mem_pkg::word_t ref_mem [256];  // Mirror of the memory contents
  logic [7:0]            exp_data[$];
  logic                  exp_last[$];
  logic [7:0]            rx_data[$];
  logic                  rx_last[$];
  int                    errors = 0;
  int                    checks = 0;
  int                    cycles = 0;
  int                    stall_pct = 25;
  logic                  hold_pending = 1'b0;
  logic [7:0]            held_data;
  int                    errs_before;

  memreq_top i_memreq_top (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .s_tvalid_i(s_tvalid), .s_tready_o(s_tready), .s_tlast_i(s_tlast), .s_tdata_i(s_tdata),
    .m_tvalid_o(m_tvalid), .m_tready_i(m_tready), .m_tlast_o(m_tlast), .m_tdata_o(m_tdata),
    .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
    .mem_wdata_o(mem_wdata), .mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata),
    .mem_err_i(mem_err)
  );

  memreq_tb_mem i_mem (
    .bus_clock(bus_clock), .bus_reset(bus_reset), .req_i(mem_req), .we_i(mem_we),
    .addr_i(mem_addr), .wdata_i(mem_wdata), .ack_o(mem_ack), .rdata_o(mem_rdata),
    .err_o(mem_err)
  );

  function int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  initial begin
    bus_clock = 1'b0;
    forever #5 bus_clock = ~bus_clock;
  end

  always @(posedge bus_clock) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, expected responses never arrived", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Outbound collector, byte counted when taken at the coming rising edge
  always @(negedge bus_clock) begin
    if (bus_reset) begin
      m_tready = 1'b0;
    end else begin
      if (hold_pending) begin
        assert (m_tvalid && m_tdata == held_data) else begin
          $display("Outbound byte changed or dropped before it was taken at %0t", $time);
          errors++;
        end
      end
      m_tready = (lcg_next() % 100) >= stall_pct;
      if (m_tvalid && m_tready) begin
        rx_data.push_back(m_tdata);
        rx_last.push_back(m_tlast);
      end
      hold_pending = m_tvalid && !m_tready;
      held_data    = m_tdata;
    end
  end

  task automatic expect_byte(input logic [7:0] b, input logic last);
    exp_data.push_back(b);
    exp_last.push_back(last);
  endtask

  // Called on a falling edge, returns on the falling edge after the handshake
  task automatic send_byte(input logic [7:0] b, input logic last);
    s_tvalid = 1'b1;
    s_tdata  = b;
    s_tlast  = last;
    while (!s_tready) @(negedge bus_clock);
    @(negedge bus_clock);
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
  endtask

  task automatic send_header(input logic [7:0] op, input int nwords,
                             input memreq_mem_pkg::addr_t addr,
                             input memreq_mem_pkg::tag_t tag, input logic last);
    send_byte(op, 1'b0);
    send_byte(8'(nwords - 1), 1'b0);
    send_byte(addr[7:0], 1'b0);
    send_byte(addr[15:8], 1'b0);
    send_byte(addr[23:16], 1'b0);
    send_byte({tag, addr[27:24]}, last);  // Tag shares the top address byte
  endtask

  task automatic send_store(input memreq_mem_pkg::addr_t addr,
                            input memreq_mem_pkg::tag_t tag, input int nwords);
    memreq_mem_pkg::word_t w;
    logic                  bad;
    bad = addr[27];
    send_header(memreq_cmd_pkg::OP_STORE, nwords, addr, tag, 1'b0);
    for (int i = 0; i < nwords; i++) begin
      w = (lcg_next() << 16) ^ lcg_next();
      for (int k = 0; k < 4; k++) begin
        send_byte(w[8*k +: 8], (i == nwords - 1) && (k == 3));
      end
      if (!bad) ref_mem[8'(addr + i)] = w;
    end
    expect_byte(bad ? 8'h03 : 8'h02, 1'b0);
    expect_byte(8'(tag), 1'b1);
  endtask

  task automatic send_fetch(input memreq_mem_pkg::addr_t addr,
                            input memreq_mem_pkg::tag_t tag, input int nwords);
    memreq_mem_pkg::word_t w;
    send_header(memreq_cmd_pkg::OP_FETCH, nwords, addr, tag, 1'b1);
    expect_byte(addr[27] ? 8'h82 : 8'h81, 1'b0);
    expect_byte(8'(tag), 1'b0);
    for (int i = 0; i < nwords; i++) begin
      w = ref_mem[8'(addr + i)];
      for (int k = 0; k < 4; k++) begin
        expect_byte(w[8*k +: 8], (i == nwords - 1) && (k == 3));
      end
    end
  endtask

  task automatic send_nop();
    send_byte(memreq_cmd_pkg::OP_NOP, 1'b0);
    send_byte(8'h33, 1'b0);
    send_byte(8'h44, 1'b1);
  endtask

  // Waits for the expected bytes, then for a quiet spell that would show extras
  task automatic compare_rx();
    int n;
    n = exp_data.size();
    while (rx_data.size() < n) @(negedge bus_clock);
    repeat (30) @(negedge bus_clock);
    checks++;
    assert (rx_data.size() == n) else begin
      $display("Wrong outbound byte count, expected %0d bytes and received %0d",
               n, rx_data.size());
      errors++;
    end
    for (int i = 0; i < n; i++) begin
      checks++;
      assert (rx_data[i] == exp_data[i]) else begin
        $display("FAILED t=%0t m_tdata_o[%0d] expected %02h got %02h",
                 $time, i, exp_data[i], rx_data[i]);
        errors++;
      end
      assert (rx_last[i] == exp_last[i]) else begin
        $display("FAILED t=%0t m_tlast_o[%0d] expected %0b got %0b",
                 $time, i, exp_last[i], rx_last[i]);
        errors++;
      end
    end
    exp_data.delete();
    exp_last.delete();
    rx_data.delete();
    rx_last.delete();
  endtask

  task automatic report_test(input int num, input string name);
    $display("Test %0d %s: %s", num, name, (errors == errs_before) ? "ok" : "mismatches");
    errs_before = errors;
  endtask

  initial begin
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = 32'h9e37_79b9 * (i + 1);
    end
    errs_before = 0;
    bus_reset = 1'b1;
    s_tvalid  = 1'b0;
    s_tlast   = 1'b0;
    s_tdata   = 8'h00;
    m_tready  = 1'b0;
    repeat (8) @(negedge bus_clock);
    checks++;
    assert (!m_tvalid) else begin
      $display("FAILED t=%0t m_tvalid_o expected 0 got %0b", $time, m_tvalid);
      errors++;
    end
    assert (!mem_req) else begin
      $display("FAILED t=%0t mem_req_o expected 0 got %0b", $time, mem_req);
      errors++;
    end
    assert (!s_tready) else begin
      $display("FAILED t=%0t s_tready_o expected 0 got %0b", $time, s_tready);
      errors++;
    end
    bus_reset = 1'b0;
    @(negedge bus_clock);

    send_store(28'd10, 4'd5, 4);
    compare_rx();
    send_fetch(28'd10, 4'd5, 4);
    compare_rx();
    report_test(1, "store then fetch");

    send_store(28'h800_0020, 4'd9, 2);
    compare_rx();
    send_fetch(28'h800_0020, 4'd3, 2);
    compare_rx();
    report_test(2, "error region");

    send_nop();
    compare_rx();  // Nothing expected
    send_fetch(28'd10, 4'd7, 2);
    compare_rx();
    report_test(3, "unknown opcode");

    send_store(28'd40, 4'd2, 3);
    send_fetch(28'd40, 4'd4, 3);
    compare_rx();
    report_test(4, "back-to-back ordering");

    stall_pct = 80;
    for (int i = 0; i < 4; i++) begin
      send_store(28'(100 + 6 * i), 4'(i), 6);
    end
    send_fetch(28'd100, 4'd12, 24);
    compare_rx();
    stall_pct = 25;
    report_test(5, "back-pressure");

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+include
hw/memreq_cmd_pkg.sv
hw/memreq_mem_pkg.sv
hw/cmd_parser.sv
hw/write_engine.sv
hw/read_engine.sv
hw/mem_arbiter.sv
hw/resp_arbiter.sv
hw/memreq_top.sv
dv/memreq_tb_mem.sv
dv/memreq_tb.sv

// ==== Bender.yml ====
package:
  name: memreq

sources:
  - include_dirs:
      - include
    files:
      - hw/memreq_cmd_pkg.sv
      - hw/memreq_mem_pkg.sv
      - hw/cmd_parser.sv
      - hw/write_engine.sv
      - hw/read_engine.sv
      - hw/mem_arbiter.sv
      - hw/resp_arbiter.sv
      - hw/memreq_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/memreq_tb_mem.sv
      - dv/memreq_tb.sv
